//--- Makefile
VERILATOR  ?= verilator
TOP        := board_subsys_tb
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src.f
src/board_pkg.sv
src/mem_bus_if.sv
src/bus_router.sv
src/sram_ctrl.sv
src/periph_regs.sv
src/pwr_ctrl.sv
src/board_subsys.sv
verification/board_subsys_sva.sv
verification/board_subsys_tb.sv

//--- src/board_pkg.sv
// Board subsystem package with bus widths, address map, register indices and types.
package board_pkg;

    // Bus widths.
    localparam int WORD_BITS      = 32;
    localparam int WADDR_BITS     = 18;
    localparam int SRAM_ADDR_BITS = 19;

    // Word address bit that selects the peripheral region.
    localparam int PERI_SEL_BIT = WADDR_BITS - 1;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [WORD_BITS/8-1:0]    mask_t;
    typedef logic [WADDR_BITS-1:0]     waddr_t;
    typedef logic [SRAM_ADDR_BITS-1:0] sram_addr_t;
    typedef logic [7:0]                sram_byte_t;

    // External SRAM size in bytes, as reported by the size register.
    localparam word_t SRAM_SIZE = word_t'(1) << SRAM_ADDR_BITS;

    // Peripheral register indices, from word address bits 1:0.
    localparam logic [1:0] REG_SIZE     = 2'd0;
    localparam logic [1:0] REG_GPIO_OUT = 2'd1;
    localparam logic [1:0] REG_GPIO_IN  = 2'd2;
    localparam logic [1:0] REG_PWR      = 2'd3;

    // Read data seen by the master while the system is shut down.
    localparam word_t BUS_IDLE_DATA = '1;

    // SRAM controller states.
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        STROBE,
        DONE
    } sram_state_t;

endpackage

//--- src/board_subsys.sv
// Board memory and peripheral subsystem with SRAM, GPIO LEDs and power management.
`timescale 1ns/1ns

module board_subsys (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_re,
    input  logic                  bus_we,
    input  board_pkg::waddr_t     bus_addr,
    input  board_pkg::word_t      bus_wdata,
    input  board_pkg::mask_t      bus_wmask,
    output logic                  bus_ready,
    output board_pkg::word_t      bus_rdata,
    input  logic [1:0]            btn,
    output logic                  led_r,
    output logic                  led_g,
    output logic                  led_b,
    output logic                  halted,
    output logic                  sram_oe_n,
    output logic                  sram_we_n,
    output logic                  sram_ce_n,
    output board_pkg::sram_addr_t sram_addr,
    inout  board_pkg::sram_byte_t sram_data
);
    import board_pkg::*;

    logic       sys_rst;
    logic       btn_level;
    logic       shdn_req;
    logic       rst_req;
    logic       sram_re;
    logic       sram_we;
    sram_byte_t sram_wdata;
    sram_byte_t sram_rdata;
    word_t      gpio_out;

    mem_bus_if host_bus ();
    mem_bus_if sram_bus ();
    mem_bus_if peri_bus ();

    assign host_bus.re    = bus_re;
    assign host_bus.we    = bus_we;
    assign host_bus.addr  = bus_addr;
    assign host_bus.wdata = bus_wdata;
    assign host_bus.wmask = bus_wmask;
    assign bus_ready      = host_bus.ready;
    assign bus_rdata      = host_bus.rdata;

    // SRAM pins.
    assign sram_ce_n  = 1'b0;
    assign sram_oe_n  = !(sram_re && !sram_we);
    assign sram_we_n  = !sram_we;
    assign sram_rdata = sram_data;
    assign sram_data  = sram_we ? sram_wdata : 'z;

    // LEDs are active low.
    assign led_r = !gpio_out[0];
    assign led_g = !gpio_out[1];
    assign led_b = !gpio_out[2];

    bus_router u_router (
        .clk(clk), .rst(sys_rst), .host(host_bus.slave),
        .sram_bus(sram_bus.master), .peri_bus(peri_bus.master), .halted(halted)
    );

    sram_ctrl u_sram (
        .clk(clk), .rst(sys_rst), .bus(sram_bus.slave),
        .sram_re(sram_re), .sram_we(sram_we), .sram_addr(sram_addr),
        .sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
    );

    periph_regs u_regs (
        .clk(clk), .rst(sys_rst), .bus(peri_bus.slave), .btn_level(btn_level),
        .gpio_out(gpio_out), .shdn_req(shdn_req), .rst_req(rst_req)
    );

    // Power manager derives sys_rst from the board reset and the buttons.
    pwr_ctrl u_pwr (
        .clk(clk), .rst(rst), .btn(btn), .shdn_req(shdn_req), .rst_req(rst_req),
        .sys_rst(sys_rst), .halted(halted), .btn_level(btn_level)
    );

endmodule

//--- src/bus_router.sv
// Bus router that splits host accesses between SRAM and peripherals and blocks them on halt.
`timescale 1ns/1ns

module bus_router (
    input  logic clk,
    input  logic rst,
    mem_bus_if.slave  host,
    mem_bus_if.master sram_bus,
    mem_bus_if.master peri_bus,
    input  logic halted
);
    import board_pkg::*;

    logic req;
    logic sel_peri;
    logic sram_busy;
    logic block;

    assign req      = host.re || host.we;
    assign sel_peri = host.addr[PERI_SEL_BIT];

    // An SRAM access in flight runs to completion before a halt takes over.
    assign block = halted && !sram_busy;

    assign sram_bus.re    = host.re && !block && !sel_peri;
    assign sram_bus.we    = host.we && !block && !sel_peri;
    assign sram_bus.addr  = host.addr;
    assign sram_bus.wdata = host.wdata;
    assign sram_bus.wmask = host.wmask;

    assign peri_bus.re    = host.re && !block && sel_peri;
    assign peri_bus.we    = host.we && !block && sel_peri;
    assign peri_bus.addr  = host.addr;
    assign peri_bus.wdata = host.wdata;
    assign peri_bus.wmask = host.wmask;

    always_comb begin
        if (block) begin
            host.ready = req;
            host.rdata = BUS_IDLE_DATA;
        end else if (sel_peri) begin
            host.ready = peri_bus.ready;
            host.rdata = peri_bus.rdata;
        end else begin
            host.ready = sram_bus.ready;
            host.rdata = sram_bus.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sram_busy <= 1'b0;
        end else if (sram_bus.ready) begin
            sram_busy <= 1'b0;
        end else if (sram_bus.re || sram_bus.we) begin
            sram_busy <= 1'b1;
        end
    end

endmodule

//--- src/mem_bus_if.sv
// Word-wide memory bus with request strobes, byte mask and ready handshake.
`timescale 1ns/1ns

interface mem_bus_if;
    import board_pkg::*;

    // Request, held by the master until ready.
    logic   re;
    logic   we;
    waddr_t addr;
    word_t  wdata;
    mask_t  wmask;

    // Response, rdata valid while ready is high.
    logic   ready;
    word_t  rdata;

    modport master (
        output re, we, addr, wdata, wmask,
        input  ready, rdata
    );

    modport slave (
        input  re, we, addr, wdata, wmask,
        output ready, rdata
    );

endinterface

//--- src/periph_regs.sv
// Peripheral registers for extmem size, GPIO and power control.
`timescale 1ns/1ns

module periph_regs (
    input  logic clk,
    input  logic rst,
    mem_bus_if.slave bus,
    input  logic btn_level,
    output board_pkg::word_t gpio_out,
    output logic shdn_req,
    output logic rst_req
);
    import board_pkg::*;

    logic [1:0] idx;
    logic       wr_gpio;
    logic       wr_pwr;
    word_t      gpio_in;

    assign idx = bus.addr[1:0];

    // Zero wait states.
    assign bus.ready = bus.re || bus.we;

    assign wr_gpio = bus.we && (idx == REG_GPIO_OUT);
    assign wr_pwr  = bus.we && (idx == REG_PWR);

    // Button level shows up in place of output bit 3.
    assign gpio_in = {gpio_out[31:4], btn_level, gpio_out[2:0]};

    always_comb begin
        case (idx)
            REG_SIZE:     bus.rdata = SRAM_SIZE;
            REG_GPIO_OUT: bus.rdata = gpio_out;
            REG_GPIO_IN:  bus.rdata = gpio_in;
            default:      bus.rdata = '0;
        endcase
    end

    // Power requests last only for the write cycle.
    assign shdn_req = wr_pwr && bus.wdata[0];
    assign rst_req  = wr_pwr && bus.wdata[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_out <= '0;
        end else if (wr_gpio) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wmask[b]) begin
                    gpio_out[b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/pwr_ctrl.sv
// Power manager for the system reset and the shutdown state.
`timescale 1ns/1ns

module pwr_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] btn,
    input  logic       shdn_req,
    input  logic       rst_req,
    output logic       sys_rst,
    output logic       halted,
    output logic       btn_level
);

    logic [1:0] btn_q;
    logic       rst_cond;

    // Button 0 resets the system, button 1 goes to GPIO.
    assign rst_cond  = rst || btn_q[0] || rst_req;
    assign btn_level = btn_q[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q <= 2'b00;
        end else begin
            btn_q <= btn;
        end
    end

    // Any reset source wakes the system up again.
    always_ff @(posedge clk) begin
        if (rst_cond) begin
            sys_rst <= 1'b1;
            halted  <= 1'b0;
        end else begin
            sys_rst <= 1'b0;
            if (shdn_req) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- src/sram_ctrl.sv
// SRAM controller that sequences each bus word as byte cycles on an 8-bit async SRAM.
`timescale 1ns/1ns

module sram_ctrl (
    input  logic clk,
    input  logic rst,
    mem_bus_if.slave bus,
    output logic sram_re,
    output logic sram_we,
    output board_pkg::sram_addr_t sram_addr,
    output board_pkg::sram_byte_t sram_wdata,
    input  board_pkg::sram_byte_t sram_rdata
);
    import board_pkg::*;

    sram_state_t state;

    // Lanes still to be transferred for the current access.
    logic [3:0] pending;
    logic [3:0] pending_next;
    logic [3:0] req_lanes;
    logic [1:0] cur_lane;
    word_t      rdata_q;

    // Reads always fetch the whole word, writes only the enabled bytes.
    assign req_lanes = bus.re ? 4'hf : bus.wmask;

    // Lowest lane still pending.
    always_comb begin
        cur_lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (pending[i]) begin
                cur_lane = i[1:0];
            end
        end
    end

    assign pending_next = pending & ~(4'b0001 << cur_lane);

    // Word address times four plus lane, wrapping inside the SRAM.
    assign sram_addr  = {bus.addr[SRAM_ADDR_BITS-3:0], cur_lane};
    assign sram_wdata = bus.wdata[cur_lane*8 +: 8];

    assign sram_re = (state == STROBE) && bus.re;
    assign sram_we = (state == STROBE) && bus.we;

    assign bus.ready = (state == DONE);
    assign bus.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            pending <= 4'h0;
        end else begin
            case (state)
                IDLE: begin
                    if (bus.re || bus.we) begin
                        pending <= req_lanes;
                        // Empty write mask has nothing to do.
                        state   <= (req_lanes == 4'h0) ? DONE : SETUP;
                    end
                end
                SETUP: begin
                    state <= STROBE;
                end
                STROBE: begin
                    pending <= pending_next;
                    state   <= (pending_next == 4'h0) ? DONE : SETUP;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Capture the read byte at the end of its strobe.
    always_ff @(posedge clk) begin
        if (state == STROBE && bus.re) begin
            rdata_q[cur_lane*8 +: 8] <= sram_rdata;
        end
    end

endmodule

//--- verification/board_subsys_sva.sv
// Assertions on the board subsystem bus handshake and SRAM control pins.
`timescale 1ns/1ns

module board_subsys_sva (
    input logic              clk,
    input logic              rst,
    input logic              bus_re,
    input logic              bus_we,
    input board_pkg::waddr_t bus_addr,
    input board_pkg::word_t  bus_wdata,
    input board_pkg::mask_t  bus_wmask,
    input logic              bus_ready,
    input logic              sram_we_n,
    input logic              sram_oe_n
);

    // Ready only answers a pending request.
    ready_needs_req: assert property (@(posedge clk) disable iff (rst)
        bus_ready |-> (bus_re || bus_we))
        else $error("bus_ready high without re or we");

    // Output enable only during a read request.
    sram_oe_on_read: assert property (@(posedge clk) disable iff (rst)
        !sram_oe_n |-> (bus_re && !bus_we))
        else $error("sram_oe_n low outside a read request");

    // Write enable only during a write request.
    sram_we_on_write: assert property (@(posedge clk) disable iff (rst)
        !sram_we_n |-> (bus_we && !bus_re))
        else $error("sram_we_n low outside a write request");

    // Master holds the whole request until ready.
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_re || bus_we) && !bus_ready |=>
            $stable({bus_re, bus_we, bus_addr, bus_wdata, bus_wmask}))
        else $error("bus request changed before ready");

endmodule

//--- verification/board_subsys_tb.sv
// Testbench for the board subsystem with an SRAM model and a table of bus operations.
`timescale 1ns/1ns

module board_subsys_tb;
    import board_pkg::*;

    localparam int READY_TIMEOUT = 100;

    // Peripheral word addresses with the region bit set.
    localparam waddr_t A_SIZE     = {1'b1, 15'd0, REG_SIZE};
    localparam waddr_t A_GPIO_OUT = {1'b1, 15'd0, REG_GPIO_OUT};
    localparam waddr_t A_GPIO_IN  = {1'b1, 15'd0, REG_GPIO_IN};
    localparam waddr_t A_PWR      = {1'b1, 15'd0, REG_PWR};

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_BTN, OP_HALT, OP_LED} op_t;

    typedef struct {
        op_t    op;
        waddr_t addr;
        word_t  data;
        mask_t  mask;
        word_t  exp_val;
    } row_t;

    logic       clk;
    logic       rst;
    logic       bus_re;
    logic       bus_we;
    waddr_t     bus_addr;
    word_t      bus_wdata;
    mask_t      bus_wmask;
    logic       bus_ready;
    word_t      bus_rdata;
    logic [1:0] btn;
    logic       led_r;
    logic       led_g;
    logic       led_b;
    logic       halted;
    logic       sram_oe_n;
    logic       sram_we_n;
    logic       sram_ce_n;
    sram_addr_t sram_addr;
    wire  [7:0] sram_data;

    sram_byte_t sram_mem [0:(1 << SRAM_ADDR_BITS) - 1];
    row_t       rows[$];
    int         errors;
    int         seed;

    board_subsys u_board_subsys (
        .clk(clk), .rst(rst), .bus_re(bus_re), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_wmask(bus_wmask), .bus_ready(bus_ready),
        .bus_rdata(bus_rdata), .btn(btn), .led_r(led_r), .led_g(led_g), .led_b(led_b),
        .halted(halted), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
        .sram_ce_n(sram_ce_n), .sram_addr(sram_addr), .sram_data(sram_data)
    );

    bind board_subsys board_subsys_sva u_sva (
        .clk(clk), .rst(rst), .bus_re(bus_re), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_wmask(bus_wmask), .bus_ready(bus_ready),
        .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n)
    );

    always #10 clk = ~clk;

    // Async SRAM model with one byte per address.
    assign sram_data = !sram_oe_n ? sram_mem[sram_addr] : 8'hzz;

    always @(posedge clk) begin
        if (!sram_we_n) begin
            sram_mem[sram_addr] <= sram_data;
        end
    end

    function automatic void add_row(op_t op, waddr_t addr, word_t data, mask_t mask,
                                    word_t exp_val);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.data    = data;
        r.mask    = mask;
        r.exp_val = exp_val;
        rows.push_back(r);
    endfunction

    // LED pins are the inverse of GPIO bits 0 to 2.
    function automatic void add_led_row(word_t gpio);
        add_row(OP_LED, '0, gpio, '0, {29'd0, ~gpio[2:0]});
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp_val);
        if (got !== exp_val) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp_val);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp_val);
            errors++;
        end
    endtask

    task automatic bus_access(input logic wr, input waddr_t addr, input word_t wdata,
                              input mask_t mask, output word_t rdata);
        int waited;
        @(negedge clk);
        bus_re    = !wr;
        bus_we    = wr;
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_wmask = mask;
        waited    = 0;
        #1;
        while (!bus_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!bus_ready) begin
            $display("Timeout: no bus_ready for access at word address %h", addr);
            $display("Testbench failed");
            $finish;
        end else begin
            rdata = bus_rdata;
            // Handshake completes on the next rising edge.
            @(posedge clk);
            @(negedge clk);
            bus_re = 1'b0;
            bus_we = 1'b0;
        end
    endtask

    task automatic fill_table(input waddr_t rnd_addr, input word_t rnd_data);
        add_row(OP_HALT, '0, '0, '0, 32'd0);
        add_led_row(32'd0);
        add_row(OP_WRITE, 18'h00000, 32'h0123_4567, 4'hf, '0);
        add_row(OP_WRITE, 18'h00001, 32'h89ab_cdef, 4'hf, '0);
        add_row(OP_WRITE, 18'h1ffff, 32'hdead_beef, 4'hf, '0);
        add_row(OP_WRITE, rnd_addr, rnd_data, 4'hf, '0);
        add_row(OP_READ, 18'h00000, '0, '0, 32'h0123_4567);
        add_row(OP_READ, 18'h00001, '0, '0, 32'h89ab_cdef);
        add_row(OP_READ, 18'h1ffff, '0, '0, 32'hdead_beef);
        add_row(OP_READ, rnd_addr, '0, '0, rnd_data);
        // Partial masks merge into the stored word.
        add_row(OP_WRITE, 18'h00100, 32'h1122_3344, 4'hf, '0);
        add_row(OP_WRITE, 18'h00100, 32'haabb_ccdd, 4'b0101, '0);
        add_row(OP_READ, 18'h00100, '0, '0, 32'h11bb_33dd);
        add_row(OP_WRITE, 18'h00100, 32'hffff_ffff, 4'h0, '0);
        add_row(OP_READ, 18'h00100, '0, '0, 32'h11bb_33dd);
        add_row(OP_READ, A_SIZE, '0, '0, 32'h0008_0000);
        add_row(OP_WRITE, A_GPIO_OUT, 32'h1234_56a5, 4'hf, '0);
        add_row(OP_WRITE, A_GPIO_OUT, 32'h0000_7700, 4'b0010, '0);
        add_row(OP_READ, A_GPIO_OUT, '0, '0, 32'h1234_77a5);
        add_led_row(32'h1234_77a5);
        add_row(OP_BTN, '0, 32'd2, '0, '0);
        add_row(OP_READ, A_GPIO_IN, '0, '0, 32'h1234_77ad);
        add_row(OP_READ, A_PWR, '0, '0, 32'd0);
        // Soft reset from software.
        add_row(OP_WRITE, A_PWR, 32'd2, 4'hf, '0);
        add_row(OP_HALT, '0, '0, '0, 32'd0);
        add_led_row(32'd0);
        add_row(OP_READ, A_GPIO_OUT, '0, '0, 32'd0);
        add_row(OP_READ, 18'h1ffff, '0, '0, 32'hdead_beef);
        // Shutdown, blocked accesses, then the reset button.
        add_row(OP_WRITE, 18'h00200, 32'hcafe_f00d, 4'hf, '0);
        add_row(OP_WRITE, A_GPIO_OUT, 32'h0000_0005, 4'hf, '0);
        add_row(OP_WRITE, A_PWR, 32'd1, 4'hf, '0);
        add_row(OP_HALT, '0, '0, '0, 32'd1);
        add_row(OP_READ, 18'h00200, '0, '0, 32'hffff_ffff);
        add_row(OP_WRITE, 18'h00200, 32'h0bad_0bad, 4'hf, '0);
        add_row(OP_WRITE, A_GPIO_OUT, 32'h0000_0007, 4'hf, '0);
        add_led_row(32'h0000_0005);
        add_row(OP_READ, A_SIZE, '0, '0, 32'hffff_ffff);
        add_row(OP_BTN, '0, 32'd1, '0, '0);
        add_row(OP_BTN, '0, 32'd0, '0, '0);
        add_row(OP_HALT, '0, '0, '0, 32'd0);
        add_led_row(32'd0);
        add_row(OP_READ, 18'h00200, '0, '0, 32'hcafe_f00d);
        add_row(OP_READ, rnd_addr, '0, '0, rnd_data);
    endtask

    initial begin
        row_t   r;
        word_t  rdata;
        word_t  rnd_word;
        waddr_t rnd_addr;
        int     errors_before;
        clk       = 1'b0;
        rst       = 1'b1;
        bus_re    = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_wmask = '0;
        btn       = 2'b00;
        errors    = 0;
        seed      = 32'h72e1_f1c5;
        // Random SRAM word on an even address in the upper half and clear of fixed rows.
        rnd_word = word_t'($random(seed));
        rnd_addr = {2'b01, rnd_word[15:1], 1'b0};
        fill_table(rnd_addr, word_t'($random(seed)));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            errors_before = errors;
            case (r.op)
                OP_WRITE: begin
                    bus_access(1'b1, r.addr, r.data, r.mask, rdata);
                end
                OP_READ: begin
                    bus_access(1'b0, r.addr, '0, '0, rdata);
                    check_word("bus_rdata", rdata, r.exp_val);
                end
                OP_BTN: begin
                    @(negedge clk);
                    btn = r.data[1:0];
                    repeat (2) @(negedge clk);
                end
                OP_HALT: begin
                    @(negedge clk);
                    check_bit("halted", halted, r.exp_val[0]);
                end
                default: begin
                    @(negedge clk);
                    check_bit("led_r", led_r, r.exp_val[0]);
                    check_bit("led_g", led_g, r.exp_val[1]);
                    check_bit("led_b", led_b, r.exp_val[2]);
                    check_bit("sram_ce_n", sram_ce_n, 1'b0);
                end
            endcase
            $display("row %0d %s addr %h: %s", i, r.op.name(), r.addr,
                     (errors == errors_before) ? "ok" : "mismatch");
        end
        $display("Rows run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
